// ==== Makefile ====
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build fp_cmp_tb with Verilator, run it and check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"

test:
	verilator --binary --timing --assert --top-module fp_cmp_tb \
		-f fp_cmp.f -Mdir obj_dir -o fp_cmp_sim
	./obj_dir/fp_cmp_sim > $(LOG) 2>&1; cat $(LOG)
	@grep -q "TEST PASSED" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// ==== fp_cmp.f ====
+incdir+hdl
hdl/fp_format_pkg.sv
hdl/fp_cmp_op_pkg.sv
hdl/fp_operand_decode.sv
hdl/fp_magnitude_compare.sv
hdl/fp_cmp_result.sv
hdl/fp_cmp_unit.sv
tb/fp_cmp_tb.sv

// ==== hdl/fp_cmp_op_pkg.sv ====
package fp_cmp_op_pkg;

    // Compare operations of the unit.
    // FEQ/FLT/FLE return 0 or 1, FMIN/FMAX return one of the operands
    typedef enum logic [2:0] {
        CMP_FEQ  = 3'd0,
        CMP_FLT  = 3'd1,
        CMP_FLE  = 3'd2,
        CMP_FMIN = 3'd3,
        CMP_FMAX = 3'd4
    } cmp_op_e;

endpackage

// ==== hdl/fp_cmp_result.sv ====
`timescale 1ns/1ns
`include "fp_cmp_settings.svh"

module fp_cmp_result (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     s1_stb,
    input  fp_cmp_op_pkg::cmp_op_e   s1_op,
    input  fp_format_pkg::fp_word_t  s1_a,
    input  fp_format_pkg::fp_word_t  s1_b,
    input  logic                     s1_lt,
    input  logic                     s1_eq,
    input  logic                     s1_unordered,
    input  logic                     s1_any_snan,
    input  logic                     s1_a_nan,
    output logic                     out_stb,
    output fp_format_pkg::fp_word_t  out_z,
    output logic                     out_invalid
);
    import fp_format_pkg::*;
    import fp_cmp_op_pkg::*;

    fp_fields_t b_fields;
    logic       b_field_nan;
    logic       b_nan;
    logic       is_min;
    logic       pick_a;
    fp_word_t   minmax;
    fp_word_t   z;
    logic       invalid;

    ////////////////////////////////////////////////////////////
    // NaN status of b
    ////////////////////////////////////////////////////////////

    // Unordered without a NaN on a means b is the NaN.
    // With a NaN on a, b's fields tell whether both are NaN
    assign b_fields    = fp_fields_t'(s1_b);
    assign b_field_nan = (b_fields.exponent == EXP_ALL_ONES) && (|b_fields.fraction);
    assign b_nan       = s1_unordered && (!s1_a_nan || b_field_nan);

    ////////////////////////////////////////////////////////////
    // FMIN / FMAX selection
    ////////////////////////////////////////////////////////////

    assign is_min = (s1_op == CMP_FMIN);

    always_comb begin
        if (s1_eq) begin
            // Equal values; only +0/-0 differ, min keeps the negative one
            pick_a = is_min ? s1_a[`FP_WIDTH-1] : !s1_a[`FP_WIDTH-1];
        end else begin
            pick_a = is_min ? s1_lt : !s1_lt;
        end
    end

    always_comb begin
        if (s1_a_nan && b_nan) begin
            minmax = `FP_CANON_NAN;
        end else if (s1_a_nan) begin
            minmax = s1_b;
        end else if (b_nan) begin
            minmax = s1_a;
        end else begin
            minmax = pick_a ? s1_a : s1_b;
        end
    end

    ////////////////////////////////////////////////////////////
    // Per-operation result and invalid flag
    ////////////////////////////////////////////////////////////

    always_comb begin
        z       = '0;
        invalid = 1'b0;
        case (s1_op)
            CMP_FEQ: begin
                z[0]    = s1_eq;
                invalid = s1_any_snan;
            end
            CMP_FLT: begin
                z[0]    = s1_lt;
                invalid = s1_unordered;
            end
            CMP_FLE: begin
                z[0]    = s1_lt || s1_eq;
                invalid = s1_unordered;
            end
            CMP_FMIN,
            CMP_FMAX: begin
                z       = minmax;
                invalid = s1_any_snan;
            end
            default: begin
                z       = '0;
                invalid = 1'b0;
            end
        endcase
    end

    // Result holds until the next strobe
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_stb     <= 1'b0;
            out_z       <= '0;
            out_invalid <= 1'b0;
        end else begin
            out_stb <= s1_stb;
            if (s1_stb) begin
                out_z       <= z;
                out_invalid <= invalid;
            end
        end
    end

endmodule

// ==== hdl/fp_cmp_settings.svh ====
`ifndef FP_CMP_SETTINGS_SVH
`define FP_CMP_SETTINGS_SVH

// Single-precision format
`define FP_WIDTH     32
`define FP_EXP_BITS  8
`define FP_MANT_BITS 23

// Quiet NaN returned by FMIN/FMAX when both inputs are NaN
`define FP_CANON_NAN 32'h7FC0_0000

// Cycles from in_stb to out_stb
`define CMP_LATENCY  2

`endif

// ==== hdl/fp_cmp_unit.sv ====
`timescale 1ns/1ns

module fp_cmp_unit (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     in_stb,
    input  fp_cmp_op_pkg::cmp_op_e   in_op,
    input  fp_format_pkg::fp_word_t  in_a,
    input  fp_format_pkg::fp_word_t  in_b,
    output logic                     out_stb,
    output fp_format_pkg::fp_word_t  out_z,
    output logic                     out_invalid
);
    import fp_format_pkg::*;
    import fp_cmp_op_pkg::*;

    // Decoded operand fields
    logic    a_sign;
    logic    b_sign;
    fp_mag_t a_mag;
    fp_mag_t b_mag;
    logic    a_nan;
    logic    b_nan;
    logic    a_snan;
    logic    b_snan;
    logic    a_zero;
    logic    b_zero;

    // Stage 1 to stage 2
    logic     s1_stb;
    cmp_op_e  s1_op;
    fp_word_t s1_a;
    fp_word_t s1_b;
    logic     s1_lt;
    logic     s1_eq;
    logic     s1_unordered;
    logic     s1_any_snan;
    logic     s1_a_nan;

    ////////////////////////////////////////////////////////////
    // Operand decode
    ////////////////////////////////////////////////////////////

    fp_operand_decode u_dec_a (
        .word    (in_a),
        .sign    (a_sign),
        .mag     (a_mag),
        .is_nan  (a_nan),
        .is_snan (a_snan),
        .is_zero (a_zero)
    );

    fp_operand_decode u_dec_b (
        .word    (in_b),
        .sign    (b_sign),
        .mag     (b_mag),
        .is_nan  (b_nan),
        .is_snan (b_snan),
        .is_zero (b_zero)
    );

    ////////////////////////////////////////////////////////////
    // Two pipeline stages
    ////////////////////////////////////////////////////////////

    fp_magnitude_compare u_compare (
        .clk          (clk),
        .arst_n       (arst_n),
        .in_stb       (in_stb),
        .in_op        (in_op),
        .a            (in_a),
        .b            (in_b),
        .a_sign       (a_sign),
        .b_sign       (b_sign),
        .a_mag        (a_mag),
        .b_mag        (b_mag),
        .a_nan        (a_nan),
        .b_nan        (b_nan),
        .a_snan       (a_snan),
        .b_snan       (b_snan),
        .a_zero       (a_zero),
        .b_zero       (b_zero),
        .s1_stb       (s1_stb),
        .s1_op        (s1_op),
        .s1_a         (s1_a),
        .s1_b         (s1_b),
        .s1_lt        (s1_lt),
        .s1_eq        (s1_eq),
        .s1_unordered (s1_unordered),
        .s1_any_snan  (s1_any_snan),
        .s1_a_nan     (s1_a_nan)
    );

    fp_cmp_result u_result (
        .clk          (clk),
        .arst_n       (arst_n),
        .s1_stb       (s1_stb),
        .s1_op        (s1_op),
        .s1_a         (s1_a),
        .s1_b         (s1_b),
        .s1_lt        (s1_lt),
        .s1_eq        (s1_eq),
        .s1_unordered (s1_unordered),
        .s1_any_snan  (s1_any_snan),
        .s1_a_nan     (s1_a_nan),
        .out_stb      (out_stb),
        .out_z        (out_z),
        .out_invalid  (out_invalid)
    );

endmodule

// ==== hdl/fp_format_pkg.sv ====
`include "fp_cmp_settings.svh"

package fp_format_pkg;

    // Raw operand as it arrives on the bus
    typedef logic [`FP_WIDTH-1:0] fp_word_t;

    // Biased exponent and fraction fields
    typedef logic [`FP_EXP_BITS-1:0]  fp_exp_t;
    typedef logic [`FP_MANT_BITS-1:0] fp_mant_t;

    // Exponent and fraction taken together as one unsigned number.
    // Denormals sit below normals and infinity sits on top, so a plain
    // unsigned compare gives the magnitude order.
    typedef logic [`FP_WIDTH-2:0] fp_mag_t;

    // Field view of one operand
    typedef struct packed {
        logic     sign;
        fp_exp_t  exponent;
        fp_mant_t fraction;
    } fp_fields_t;

    // Exponent value shared by infinity and NaN
    localparam fp_exp_t EXP_ALL_ONES = '1;

endpackage

// ==== hdl/fp_magnitude_compare.sv ====
`timescale 1ns/1ns

module fp_magnitude_compare (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     in_stb,
    input  fp_cmp_op_pkg::cmp_op_e   in_op,
    input  fp_format_pkg::fp_word_t  a,
    input  fp_format_pkg::fp_word_t  b,
    input  logic                     a_sign,
    input  logic                     b_sign,
    input  fp_format_pkg::fp_mag_t   a_mag,
    input  fp_format_pkg::fp_mag_t   b_mag,
    input  logic                     a_nan,
    input  logic                     b_nan,
    input  logic                     a_snan,
    input  logic                     b_snan,
    input  logic                     a_zero,
    input  logic                     b_zero,
    output logic                     s1_stb,
    output fp_cmp_op_pkg::cmp_op_e   s1_op,
    output fp_format_pkg::fp_word_t  s1_a,
    output fp_format_pkg::fp_word_t  s1_b,
    output logic                     s1_lt,
    output logic                     s1_eq,
    output logic                     s1_unordered,
    output logic                     s1_any_snan,
    output logic                     s1_a_nan
);

    logic unordered;
    logic both_zero;
    logic mag_eq;
    logic mag_lt;
    logic lt;
    logic eq;

    ////////////////////////////////////////////////////////////
    // Ordering of a against b
    ////////////////////////////////////////////////////////////

    assign unordered = a_nan || b_nan;
    assign both_zero = a_zero && b_zero;
    assign mag_eq    = (a_mag == b_mag);
    assign mag_lt    = (a_mag < b_mag);

    always_comb begin
        lt = 1'b0;
        eq = 1'b0;
        if (unordered) begin
            // NaN on either side, neither less nor equal
            lt = 1'b0;
        end else if (both_zero) begin
            eq = 1'b1;
        end else if (a_sign != b_sign) begin
            // Negative side is the lesser one
            lt = a_sign;
        end else if (mag_eq) begin
            eq = 1'b1;
        end else if (a_sign) begin
            // Both negative: larger magnitude is less
            lt = !mag_lt;
        end else begin
            lt = mag_lt;
        end
    end

    ////////////////////////////////////////////////////////////
    // Stage 1 registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_stb <= 1'b0;
        end else begin
            s1_stb <= in_stb;
        end
    end

    // Payload only moves on a strobe
    always_ff @(posedge clk) begin
        if (in_stb) begin
            s1_op        <= in_op;
            s1_a         <= a;
            s1_b         <= b;
            s1_lt        <= lt;
            s1_eq        <= eq;
            s1_unordered <= unordered;
            s1_any_snan  <= a_snan || b_snan;
            s1_a_nan     <= a_nan;
        end
    end

endmodule

// ==== hdl/fp_operand_decode.sv ====
`timescale 1ns/1ns
`include "fp_cmp_settings.svh"

module fp_operand_decode (
    input  fp_format_pkg::fp_word_t word,
    output logic                    sign,
    output fp_format_pkg::fp_mag_t  mag,
    output logic                    is_nan,
    output logic                    is_snan,
    output logic                    is_zero
);
    import fp_format_pkg::*;

    fp_fields_t fields;
    logic       exp_max;
    logic       frac_nonzero;
    logic       quiet_bit;

    assign fields = fp_fields_t'(word);

    assign sign = fields.sign;
    assign mag  = {fields.exponent, fields.fraction};

    // Exponent all ones is either infinity or NaN
    assign exp_max      = (fields.exponent == EXP_ALL_ONES);
    assign frac_nonzero = |fields.fraction;

    // Top fraction bit set marks a quiet NaN
    assign quiet_bit = fields.fraction[`FP_MANT_BITS-1];

    assign is_nan  = exp_max && frac_nonzero;
    assign is_snan = is_nan && !quiet_bit;

    // Sign is ignored here, +0 and -0 both count as zero
    assign is_zero = (mag == '0);

endmodule

// ==== tb/fp_cmp_tb.sv ====
`timescale 1ns/1ns
`include "fp_cmp_settings.svh"

module fp_cmp_tb;
    import fp_format_pkg::*;
    import fp_cmp_op_pkg::*;

    // Expected result of one operation, queued in issue order
    typedef struct packed {
        cmp_op_e  op;
        fp_word_t a;
        fp_word_t b;
        fp_word_t z;
        logic     invalid;
    } expect_t;

    // Tests take about 1100 cycles
    localparam int MAX_CYCLES = 2000;

    logic     clk;
    logic     arst_n;
    logic     in_stb;
    cmp_op_e  in_op;
    fp_word_t in_a;
    fp_word_t in_b;
    logic     out_stb;
    fp_word_t out_z;
    logic     out_invalid;

    expect_t  exp_q[$];
    int       stb_q[$];
    expect_t  cur;
    int       issued;
    int       cycle  = 0;
    int       errors = 0;
    int       checks = 0;
    integer   seed;

    fp_cmp_unit u_fp_cmp_unit (
        .clk         (clk),
        .arst_n      (arst_n),
        .in_stb      (in_stb),
        .in_op       (in_op),
        .in_a        (in_a),
        .in_b        (in_b),
        .out_stb     (out_stb),
        .out_z       (out_z),
        .out_invalid (out_invalid)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    function automatic logic nan_of(input fp_word_t w);
        return (w[30:23] == 8'hFF) && (w[22:0] != 23'd0);
    endfunction

    function automatic logic snan_of(input fp_word_t w);
        return nan_of(w) && !w[22];
    endfunction

    function automatic logic zero_of(input fp_word_t w);
        return w[30:0] == 31'd0;
    endfunction

    // Unsigned key in numeric order, -0 lands just below +0
    function automatic fp_word_t order_key(input fp_word_t w);
        return w[31] ? ~w : (w | 32'h8000_0000);
    endfunction

    function automatic expect_t model(input cmp_op_e op, input fp_word_t a, input fp_word_t b);
        expect_t e;
        logic    unord;
        logic    lt;
        logic    eq;
        unord     = nan_of(a) || nan_of(b);
        eq        = !unord && ((a == b) || (zero_of(a) && zero_of(b)));
        lt        = !unord && !eq && (order_key(a) < order_key(b));
        e.op      = op;
        e.a       = a;
        e.b       = b;
        e.z       = '0;
        e.invalid = snan_of(a) || snan_of(b);
        case (op)
            CMP_FEQ: e.z[0] = eq;
            CMP_FLT: begin
                e.z[0]    = lt;
                e.invalid = unord;
            end
            CMP_FLE: begin
                e.z[0]    = lt || eq;
                e.invalid = unord;
            end
            default: begin
                if (nan_of(a) && nan_of(b))
                    e.z = `FP_CANON_NAN;
                else if (nan_of(a))
                    e.z = b;
                else if (nan_of(b))
                    e.z = a;
                else if (zero_of(a) && zero_of(b))
                    // Min takes either sign bit, max needs both
                    e.z = (op == CMP_FMIN) ? (a | b) : (a & b);
                else if (op == CMP_FMIN)
                    e.z = lt ? a : b;
                else
                    e.z = lt ? b : a;
            end
        endcase
        return e;
    endfunction

    ////////////////////////////////////////////////////////////
    // Result monitor
    ////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (arst_n && in_stb) begin
            stb_q.push_back(cycle);
        end
        if (out_stb) begin
            if (exp_q.size() == 0 || stb_q.size() == 0) begin
                $display("Result strobe at %0t with no operation outstanding", $time);
                errors++;
            end else begin
                cur    = exp_q.pop_front();
                issued = stb_q.pop_front();
                checks++;
                assert (cycle - issued == `CMP_LATENCY) else begin
                    $display("[FAIL] %0t: latency %0d cycles, expected %0d",
                             $time, cycle - issued, `CMP_LATENCY);
                    errors++;
                end
                assert (out_z == cur.z && out_invalid == cur.invalid) else begin
                    $display("[FAIL] %0t: %s a=%h b=%h gave z=%h inv=%b, expected z=%h inv=%b",
                             $time, cur.op.name(), cur.a, cur.b, out_z, out_invalid,
                             cur.z, cur.invalid);
                    errors++;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////

    // Called just after a rising edge, returns after the next one
    task automatic issue(input cmp_op_e op, input fp_word_t a, input fp_word_t b);
        exp_q.push_back(model(op, a, b));
        in_stb <= 1'b1;
        in_op  <= op;
        in_a   <= a;
        in_b   <= b;
        @(posedge clk);
    endtask

    task automatic drain();
        in_stb <= 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
    endtask

    task automatic check_one(input cmp_op_e op, input fp_word_t a, input fp_word_t b);
        issue(op, a, b);
        drain();
    endtask

    task automatic compares_both_orders(input fp_word_t a, input fp_word_t b);
        check_one(CMP_FEQ, a, b);
        check_one(CMP_FLT, a, b);
        check_one(CMP_FLE, a, b);
        check_one(CMP_FEQ, b, a);
        check_one(CMP_FLT, b, a);
        check_one(CMP_FLE, b, a);
    endtask

    task automatic minmax_both_orders(input fp_word_t a, input fp_word_t b);
        check_one(CMP_FMIN, a, b);
        check_one(CMP_FMAX, a, b);
        check_one(CMP_FMIN, b, a);
        check_one(CMP_FMAX, b, a);
    endtask

    // b is often related to a so that ties and NaNs show up
    task automatic random_pair(output fp_word_t a, output fp_word_t b);
        int unsigned sel;
        a   = $random(seed);
        sel = $unsigned($random(seed)) % 5;
        case (sel)
            0: b = a;
            1: b = a ^ 32'h8000_0000;
            2: b = a + 32'd1;
            3: b = {a[31], 8'hFF, a[22:0] | 23'd1};
            default: b = $random(seed);
        endcase
    endtask

    task automatic check_idle(input string phase);
        checks++;
        assert (!out_stb && out_z == '0 && !out_invalid) else begin
            $display("[FAIL] %0t: outputs not idle %s, stb=%b z=%h inv=%b",
                     $time, phase, out_stb, out_z, out_invalid);
            errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////

    task automatic test_reset();
        repeat (8) begin
            @(negedge clk);
            check_idle("during reset");
        end
        @(posedge clk);
        arst_n <= 1'b1;
        repeat (4) begin
            @(negedge clk);
            check_idle("after reset");
        end
        @(posedge clk);
    endtask

    task automatic test_ordered();
        fp_word_t a;
        fp_word_t b;
        compares_both_orders(32'h3F80_0000, 32'h3F80_0000);
        compares_both_orders(32'h3F80_0000, 32'hBF80_0000);
        compares_both_orders(32'h4000_0000, 32'h3F80_0000);
        compares_both_orders(32'hC000_0000, 32'hBF80_0000);
        compares_both_orders(32'h3F80_0001, 32'h3F80_0000);
        compares_both_orders(32'hBF80_0001, 32'hBF80_0000);
        // Denormals and the step into normals
        compares_both_orders(32'h0000_0001, 32'h0000_0002);
        compares_both_orders(32'h807F_FFFF, 32'h0000_0001);
        compares_both_orders(32'h007F_FFFF, 32'h0080_0000);
        // Infinities
        compares_both_orders(32'h7F80_0000, 32'h7F7F_FFFF);
        compares_both_orders(32'hFF80_0000, 32'h7F80_0000);
        compares_both_orders(32'hFF80_0000, 32'hFF7F_FFFF);
        repeat (200) begin
            random_pair(a, b);
            issue(CMP_FEQ, a, b);
            issue(CMP_FLT, a, b);
            issue(CMP_FLE, a, b);
        end
        drain();
    endtask

    task automatic test_zero_and_nan();
        fp_word_t pairs[7][2];
        pairs = '{'{32'h0000_0000, 32'h8000_0000}, '{32'h8000_0000, 32'h0000_0000},
                  '{32'h7FC0_0000, 32'h3F80_0000}, '{32'h3F80_0000, 32'h7FC0_0000},
                  '{32'h7F80_0001, 32'hBF80_0000}, '{32'hBF80_0000, 32'h7F80_0001},
                  '{32'hFFC0_0001, 32'h7F80_0001}};
        foreach (pairs[i]) begin
            check_one(CMP_FEQ, pairs[i][0], pairs[i][1]);
            check_one(CMP_FLT, pairs[i][0], pairs[i][1]);
            check_one(CMP_FLE, pairs[i][0], pairs[i][1]);
            check_one(CMP_FMIN, pairs[i][0], pairs[i][1]);
            check_one(CMP_FMAX, pairs[i][0], pairs[i][1]);
        end
    endtask

    task automatic test_min_max();
        minmax_both_orders(32'h3F80_0000, 32'h4000_0000);
        minmax_both_orders(32'hBF80_0000, 32'h4000_0000);
        minmax_both_orders(32'hC040_0000, 32'hC000_0000);
        minmax_both_orders(32'h0000_0000, 32'h8000_0000);
        minmax_both_orders(32'h7FC0_0000, 32'hC000_0000);
        minmax_both_orders(32'h7F80_0001, 32'h0000_0001);
        // Two NaNs give the canonical NaN
        minmax_both_orders(32'h7FC0_0000, 32'hFFC0_1234);
        minmax_both_orders(32'h7F80_0001, 32'h7FC0_0000);
    endtask

    task automatic test_back_to_back();
        fp_word_t    a;
        fp_word_t    b;
        int unsigned idx;
        repeat (50) begin
            random_pair(a, b);
            idx = $unsigned($random(seed)) % 5;
            issue(cmp_op_e'(idx[2:0]), a, b);
        end
        drain();
    endtask

    initial begin
        clk    = 1'b0;
        arst_n = 1'b0;
        in_stb = 1'b0;
        in_op  = CMP_FEQ;
        in_a   = '0;
        in_b   = '0;
        seed   = 79642;

        test_reset();
        test_ordered();
        test_zero_and_nan();
        test_min_max();
        test_back_to_back();

        // Idle cycles so that a stray result strobe is still caught
        repeat (4) @(posedge clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
